// ==== source/motion_defines.svh ====
`ifndef MOTION_DEFINES_SVH
`define MOTION_DEFINES_SVH

// RGB pixel, 8 bits per channel
`define PIXEL_WIDTH 24

// Grayscale value
`define GRAY_WIDTH 8

// 16-entry FIFOs
`define FIFO_ADDR_WIDTH 4

// Gray difference above this is motion
`define MOTION_THRESHOLD 50

`endif

// ==== source/motion_pkg.sv ====
`include "motion_defines.svh"

package motion_pkg;

    // Label handed from execute to result stage
    typedef enum logic [0:0] {
        PIXEL_STILL  = 1'b0,
        PIXEL_MOTION = 1'b1
    } pixel_kind_t;

    // Occupancy of a pipeline register
    typedef enum logic [0:0] {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } stage_state_t;

    // Decode stage output
    typedef struct packed {
        logic [`GRAY_WIDTH-1:0] base_gray;   // Background
        logic [`GRAY_WIDTH-1:0] image_gray;  // Live image
    } gray_pair_t;

    // Execute stage output
    typedef struct packed {
        pixel_kind_t            kind;
        logic [`GRAY_WIDTH-1:0] image_gray;  // Needed for the still case
    } classified_pixel_t;

endpackage

// ==== source/pixel_fifo.sv ====
`timescale 1ns/1ps

`include "motion_defines.svh"

module pixel_fifo #(
    parameter int ADDR_WIDTH = `FIFO_ADDR_WIDTH
) (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    wr_en,
    input  logic [`PIXEL_WIDTH-1:0] din,
    output logic                    full,

    input  logic                    rd_en,
    output logic [`PIXEL_WIDTH-1:0] dout,
    output logic                    empty
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [`PIXEL_WIDTH-1:0] mem [0:DEPTH-1];

    // Extra top bit tells a full buffer from an empty one
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_next;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]) &&
                   (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]);

    assign rd_ptr_next = rd_en ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr_next;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= din;
        end
    end

    // Registered read port that always holds the next head word.
    // A write landing on the head slot is forwarded, since the array
    // still has the old contents at this edge.
    always_ff @(posedge clock) begin
        if (wr_en && (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr_next[ADDR_WIDTH-1:0])) begin
            dout <= din;
        end else begin
            dout <= mem[rd_ptr_next[ADDR_WIDTH-1:0]];
        end
    end

    write_while_full : assert property (
        @(posedge clock) disable iff (reset)
        wr_en |-> !full
    ) else $error("pixel_fifo: write while full");

    read_while_empty : assert property (
        @(posedge clock) disable iff (reset)
        rd_en |-> !empty
    ) else $error("pixel_fifo: read while empty");

endmodule

// ==== source/gray_convert.sv ====
`timescale 1ns/1ps

`include "motion_defines.svh"

module gray_convert
    import motion_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,

    output logic                    base_rd_en,
    input  logic                    base_empty,
    input  logic [`PIXEL_WIDTH-1:0] base_dout,

    output logic                    image_rd_en,
    input  logic                    image_empty,
    input  logic [`PIXEL_WIDTH-1:0] image_dout,

    output gray_pair_t              pair,
    output stage_state_t            pair_state,
    input  logic                    pair_take
);

    logic read_pair;
    logic slot_free;

    // Sum of R, G and B over 3, truncated
    function automatic logic [`GRAY_WIDTH-1:0] to_gray(input logic [`PIXEL_WIDTH-1:0] rgb);
        logic [9:0] sum;
        logic [9:0] quotient;
        sum      = {2'b00, rgb[23:16]} + {2'b00, rgb[15:8]} + {2'b00, rgb[7:0]};
        quotient = sum / 10'd3;
        return quotient[7:0];
    endfunction

    // Free now, or emptied by the next stage on this edge
    assign slot_free = (pair_state == STAGE_EMPTY) || pair_take;
    assign read_pair = !base_empty && !image_empty && slot_free;

    assign base_rd_en  = read_pair;  // Both FIFOs pop together
    assign image_rd_en = read_pair;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pair_state <= STAGE_EMPTY;
        end else if (read_pair) begin
            pair_state <= STAGE_FULL;
        end else if (pair_take) begin
            pair_state <= STAGE_EMPTY;
        end
    end

    always_ff @(posedge clock) begin
        if (read_pair) begin
            pair.base_gray  <= to_gray(base_dout);
            pair.image_gray <= to_gray(image_dout);
        end
    end

    // A lone pop would shift the two streams against each other
    strobes_paired : assert property (
        @(posedge clock) disable iff (reset)
        base_rd_en == image_rd_en
    ) else $error("gray_convert: read strobes differ");

endmodule

// ==== source/motion_detect.sv ====
`timescale 1ns/1ps

`include "motion_defines.svh"

module motion_detect
    import motion_pkg::*;
(
    input  logic              clock,
    input  logic              reset,

    input  gray_pair_t        pair,
    input  stage_state_t      pair_state,
    output logic              pair_take,

    output classified_pixel_t pixel,
    output stage_state_t      pixel_state,
    input  logic              pixel_take
);

    logic [`GRAY_WIDTH-1:0] diff;
    pixel_kind_t            kind;

    // Magnitude only, darker and brighter count the same
    always_comb begin
        if (pair.base_gray >= pair.image_gray) begin
            diff = pair.base_gray - pair.image_gray;
        end else begin
            diff = pair.image_gray - pair.base_gray;
        end
    end

    assign kind = (diff > `GRAY_WIDTH'(`MOTION_THRESHOLD)) ? PIXEL_MOTION : PIXEL_STILL;

    // Take whenever our register is free or drains this cycle
    assign pair_take = (pair_state == STAGE_FULL) &&
                       ((pixel_state == STAGE_EMPTY) || pixel_take);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pixel_state <= STAGE_EMPTY;
        end else if (pair_take) begin
            pixel_state <= STAGE_FULL;
        end else if (pixel_take) begin
            pixel_state <= STAGE_EMPTY;
        end
    end

    always_ff @(posedge clock) begin
        if (pair_take) begin
            pixel.kind       <= kind;
            pixel.image_gray <= pair.image_gray;
        end
    end

    // Decode stage must not present an empty register as taken
    take_needs_data : assert property (
        @(posedge clock) disable iff (reset)
        pair_take |-> (pair_state == STAGE_FULL)
    ) else $error("motion_detect: pair taken while empty");

    // A pair left waiting must not change under us
    pair_held : assert property (
        @(posedge clock) disable iff (reset)
        (pair_state == STAGE_FULL) && !pair_take |=> $stable(pair)
    ) else $error("motion_detect: pending pair changed");

endmodule

// ==== source/highlight_writer.sv ====
`timescale 1ns/1ps

`include "motion_defines.svh"

module highlight_writer
    import motion_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,

    input  classified_pixel_t       pixel,
    input  stage_state_t            pixel_state,
    output logic                    pixel_take,

    output logic                    out_wr_en,
    input  logic                    out_full,
    output logic [`PIXEL_WIDTH-1:0] out_din
);

    localparam logic [`PIXEL_WIDTH-1:0] RED = 24'hFF0000;

    // Pixel waits in the execute register while the output FIFO is full
    assign out_wr_en  = (pixel_state == STAGE_FULL) && !out_full;
    assign pixel_take = out_wr_en;  // Written and released on the same edge

    always_comb begin
        case (pixel.kind)
            PIXEL_MOTION: begin
                out_din = RED;
            end
            PIXEL_STILL: begin
                out_din = {pixel.image_gray, pixel.image_gray, pixel.image_gray};
            end
            default: begin
                out_din = '0;
            end
        endcase
    end

    no_write_when_full : assert property (
        @(posedge clock) disable iff (reset)
        out_full |-> !out_wr_en
    ) else $error("highlight_writer: write attempted while output FIFO full");

    // Held pixel keeps its value until the FIFO frees up
    stall_keeps_pixel : assert property (
        @(posedge clock) disable iff (reset)
        (pixel_state == STAGE_FULL) && out_full |=>
            (pixel_state == STAGE_FULL) && $stable(pixel)
    ) else $error("highlight_writer: pixel lost during stall");

endmodule

// ==== source/motion_detect_top.sv ====
`timescale 1ns/1ps

`include "motion_defines.svh"

module motion_detect_top
    import motion_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    base_wr_en,
    input  logic [`PIXEL_WIDTH-1:0] base_din,
    output logic                    base_full,

    input  logic                    image_wr_en,
    input  logic [`PIXEL_WIDTH-1:0] image_din,
    output logic                    image_full,

    input  logic                    result_rd_en,
    output logic [`PIXEL_WIDTH-1:0] result_dout,
    output logic                    result_empty
);

    // Input FIFOs to decode
    logic                    base_rd_en;
    logic                    base_empty;
    logic [`PIXEL_WIDTH-1:0] base_dout;
    logic                    image_rd_en;
    logic                    image_empty;
    logic [`PIXEL_WIDTH-1:0] image_dout;

    // Decode to execute
    gray_pair_t              pair;
    stage_state_t            pair_state;
    logic                    pair_take;

    // Execute to result
    classified_pixel_t       pixel;
    stage_state_t            pixel_state;
    logic                    pixel_take;

    // Result to output FIFO
    logic                    out_wr_en;
    logic                    out_full;
    logic [`PIXEL_WIDTH-1:0] out_din;

    pixel_fifo u_base_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (base_wr_en),
        .din   (base_din),
        .full  (base_full),
        .rd_en (base_rd_en),
        .dout  (base_dout),
        .empty (base_empty)
    );

    pixel_fifo u_image_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (image_wr_en),
        .din   (image_din),
        .full  (image_full),
        .rd_en (image_rd_en),
        .dout  (image_dout),
        .empty (image_empty)
    );

    gray_convert u_gray_convert (
        .clock       (clock),
        .reset       (reset),
        .base_rd_en  (base_rd_en),
        .base_empty  (base_empty),
        .base_dout   (base_dout),
        .image_rd_en (image_rd_en),
        .image_empty (image_empty),
        .image_dout  (image_dout),
        .pair        (pair),
        .pair_state  (pair_state),
        .pair_take   (pair_take)
    );

    motion_detect u_motion_detect (
        .clock       (clock),
        .reset       (reset),
        .pair        (pair),
        .pair_state  (pair_state),
        .pair_take   (pair_take),
        .pixel       (pixel),
        .pixel_state (pixel_state),
        .pixel_take  (pixel_take)
    );

    highlight_writer u_highlight_writer (
        .clock       (clock),
        .reset       (reset),
        .pixel       (pixel),
        .pixel_state (pixel_state),
        .pixel_take  (pixel_take),
        .out_wr_en   (out_wr_en),
        .out_full    (out_full),
        .out_din     (out_din)
    );

    pixel_fifo u_result_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_din),
        .full  (out_full),
        .rd_en (result_rd_en),
        .dout  (result_dout),
        .empty (result_empty)
    );

endmodule

// ==== test/motion_detect_tb.sv ====
`timescale 1ns/1ps

`include "motion_defines.svh"

module motion_detect_tb;

    // One row of the directed table
    typedef struct packed {
        logic [7:0]               test_id;
        logic [`PIXEL_WIDTH-1:0]  base;
        logic [`PIXEL_WIDTH-1:0]  image;
        logic [`PIXEL_WIDTH-1:0]  expected;
    } vector_t;

    localparam int NUM_VECTORS  = 13;
    localparam int STREAM_LIMIT = 2000;  // Cycles allowed per stream
    localparam int DRAIN_CYCLES = 8;

    logic                    clock;
    logic                    reset;
    logic                    base_wr_en;
    logic [`PIXEL_WIDTH-1:0] base_din;
    logic                    base_full;
    logic                    image_wr_en;
    logic [`PIXEL_WIDTH-1:0] image_din;
    logic                    image_full;
    logic                    result_rd_en;
    logic [`PIXEL_WIDTH-1:0] result_dout;
    logic                    result_empty;

    vector_t                 vectors [0:NUM_VECTORS-1];
    logic [`PIXEL_WIDTH-1:0] pend_base [$];   // Pairs not yet written
    logic [`PIXEL_WIDTH-1:0] pend_image [$];
    logic [`PIXEL_WIDTH-1:0] expect_q [$];    // Output words in order

    int errors;
    int test_start_errors;
    int tests_run;
    int tests_failed;

    motion_detect_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .base_wr_en   (base_wr_en),
        .base_din     (base_din),
        .base_full    (base_full),
        .image_wr_en  (image_wr_en),
        .image_din    (image_din),
        .image_full   (image_full),
        .result_rd_en (result_rd_en),
        .result_dout  (result_dout),
        .result_empty (result_empty)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Gray is channel sum over 3, then threshold on the magnitude
    function automatic logic [`PIXEL_WIDTH-1:0] model_pixel(input logic [`PIXEL_WIDTH-1:0] base,
                                                            input logic [`PIXEL_WIDTH-1:0] image);
        int         base_gray;
        int         image_gray;
        int         diff;
        logic [7:0] gray;
        base_gray  = (int'(base[23:16]) + int'(base[15:8]) + int'(base[7:0])) / 3;
        image_gray = (int'(image[23:16]) + int'(image[15:8]) + int'(image[7:0])) / 3;
        diff = (base_gray > image_gray) ? base_gray - image_gray : image_gray - base_gray;
        gray = image_gray[7:0];
        if (diff > `MOTION_THRESHOLD) begin
            return 24'hFF0000;
        end else begin
            return {gray, gray, gray};
        end
    endfunction

    task automatic load_vectors();
        // Identical pixels
        vectors[0]  = {8'd2, 24'h000000, 24'h000000, 24'h000000};
        vectors[1]  = {8'd2, 24'hFFFFFF, 24'hFFFFFF, 24'hFFFFFF};
        vectors[2]  = {8'd2, 24'h808080, 24'h808080, 24'h808080};
        vectors[3]  = {8'd2, 24'h102030, 24'h102030, 24'h202020};
        vectors[4]  = {8'd2, 24'hFF0000, 24'hFF0000, 24'h555555};
        // Threshold edges, brighter and darker
        vectors[5]  = {8'd3, 24'h000000, 24'h323232, 24'h323232};
        vectors[6]  = {8'd3, 24'h000000, 24'h333333, 24'hFF0000};
        vectors[7]  = {8'd3, 24'h646464, 24'h323232, 24'h323232};
        vectors[8]  = {8'd3, 24'h646464, 24'h313131, 24'hFF0000};
        vectors[9]  = {8'd3, 24'hFFFFFF, 24'hCDCDCD, 24'hCDCDCD};
        vectors[10] = {8'd3, 24'hFFFFFF, 24'hCCCCCC, 24'hFF0000};
        vectors[11] = {8'd3, 24'h000000, 24'h980000, 24'h323232};  // 152/3 truncates to 50
        vectors[12] = {8'd3, 24'h000000, 24'h990000, 24'hFF0000};
    endtask

    task automatic queue_pair(input logic [`PIXEL_WIDTH-1:0] base,
                              input logic [`PIXEL_WIDTH-1:0] image);
        pend_base.push_back(base);
        pend_image.push_back(image);
        expect_q.push_back(model_pixel(base, image));
    endtask

    // Writes pending pairs and optionally reads results, one step per cycle
    task automatic run_stream(input bit reading, input bit until_full, output bit timed_out);
        int                      cycles;
        logic [`PIXEL_WIDTH-1:0] want;
        cycles    = 0;
        timed_out = 1'b0;
        while (!timed_out) begin
            if (until_full && (base_full || pend_base.size() == 0)) begin
                break;
            end
            if (!until_full && pend_base.size() == 0 && expect_q.size() == 0) begin
                break;
            end
            if (cycles >= STREAM_LIMIT) begin
                timed_out = 1'b1;
            end else begin
                if (pend_base.size() > 0 && !base_full && !image_full) begin
                    base_wr_en  = 1'b1;
                    base_din    = pend_base.pop_front();
                    image_wr_en = 1'b1;
                    image_din   = pend_image.pop_front();
                end else begin
                    base_wr_en  = 1'b0;
                    image_wr_en = 1'b0;
                end
                result_rd_en = 1'b0;
                if (reading && !result_empty) begin
                    assert (expect_q.size() > 0) else begin
                        $display("error at %0t: result word %06h arrived with none expected",
                                 $time, result_dout);
                        errors++;
                    end
                    if (expect_q.size() > 0) begin
                        want = expect_q.pop_front();
                        assert (result_dout === want) else begin
                            $display("mismatch at %0t: result_dout expected %06h actual %06h",
                                     $time, want, result_dout);
                            errors++;
                        end
                    end
                    result_rd_en = 1'b1;
                end
                @(posedge clock);
                #1;
                cycles++;
            end
        end
        base_wr_en   = 1'b0;
        image_wr_en  = 1'b0;
        result_rd_en = 1'b0;
    endtask

    // Nothing extra may show up once every expected word was read
    task automatic check_drained();
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            @(posedge clock);
            #1;
        end
        assert (result_empty === 1'b1) else begin
            $display("error at %0t: result FIFO holds a word %06h that no pair produced",
                     $time, result_dout);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        pend_base.delete();
        pend_image.delete();
        expect_q.delete();
    endtask

    task automatic end_test(input int id, input string name);
        tests_run++;
        if (errors > test_start_errors) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id, name, errors - test_start_errors);
        end else begin
            $display("test %0d %s: passed", id, name);
        end
    endtask

    task automatic check_timeout(input bit timed_out, input int id);
        assert (!timed_out) else begin
            $display("error at %0t: pipeline stopped moving, stream in test %0d timed out",
                     $time, id);
            errors++;
        end
    endtask

    task automatic run_table_test(input int id, input string name);
        bit timed_out;
        begin_test();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (vectors[i].test_id == id) begin
                assert (model_pixel(vectors[i].base, vectors[i].image) === vectors[i].expected)
                else begin
                    $display("error: table row %0d disagrees with the pixel model", i);
                    errors++;
                end
                queue_pair(vectors[i].base, vectors[i].image);
            end
        end
        run_stream(1'b1, 1'b0, timed_out);
        check_timeout(timed_out, id);
        check_drained();
        end_test(id, name);
    endtask

    initial begin
        bit timed_out;
        void'($urandom(32'he45bc28f));
        reset        = 1'b1;
        base_wr_en   = 1'b0;
        base_din     = '0;
        image_wr_en  = 1'b0;
        image_din    = '0;
        result_rd_en = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_vectors();

        repeat (5) @(posedge clock);
        #1 reset = 1'b0;
        @(posedge clock);
        #1;

        // Flags straight after reset
        begin_test();
        assert (result_empty === 1'b1) else begin
            $display("mismatch at %0t: result_empty expected 1 actual %b", $time, result_empty);
            errors++;
        end
        assert (base_full === 1'b0) else begin
            $display("mismatch at %0t: base_full expected 0 actual %b", $time, base_full);
            errors++;
        end
        assert (image_full === 1'b0) else begin
            $display("mismatch at %0t: image_full expected 0 actual %b", $time, image_full);
            errors++;
        end
        end_test(1, "reset state");

        run_table_test(2, "identical pixels");
        run_table_test(3, "threshold edges");

        // Fill everything with reads held off, then drain
        begin_test();
        for (int i = 0; i < 48; i++) begin
            queue_pair(24'(i * 24'h030507), 24'(i * 24'h0B0D11 + 24'h402010));
        end
        run_stream(1'b0, 1'b1, timed_out);
        check_timeout(timed_out, 4);
        assert (base_full === 1'b1) else begin
            $display("mismatch at %0t: base_full expected 1 actual %b", $time, base_full);
            errors++;
        end
        assert (image_full === 1'b1) else begin
            $display("mismatch at %0t: image_full expected 1 actual %b", $time, image_full);
            errors++;
        end
        run_stream(1'b1, 1'b0, timed_out);
        check_timeout(timed_out, 4);
        check_drained();
        end_test(4, "back-pressure");

        // Random pairs with continuous reads
        begin_test();
        for (int i = 0; i < 40; i++) begin
            queue_pair(24'($urandom), 24'($urandom));
        end
        run_stream(1'b1, 1'b0, timed_out);
        check_timeout(timed_out, 5);
        check_drained();
        end_test(5, "random stream");

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== motion_detect_top.f ====
+incdir+source
source/motion_pkg.sv
source/pixel_fifo.sv
source/gray_convert.sv
source/motion_detect.sv
source/highlight_writer.sv
source/motion_detect_top.sv
test/motion_detect_tb.sv
